/* rtl/controlDecoder.sv */
// Combinational decode of phase, subphase and opcode into bus strobes and datapath controls
`timescale 1ns/1ps
`default_nettype none

module controlDecoder
	import isaPkg::*, ctrlPkg::*;
(
	input wire phase_t Phase,
	input wire subPhase_t SubPhase,
	input wire opcode_t Opcode,
	input wire branchCode_t Branch,
	input wire logic Taken,
	input wire logic nWait,
	output busStrobe_t Strobe,
	output datapathCtrl_t Dp,
	output logic StatusWe,
	output logic IntEnable,
	output logic IntDisable
);

	localparam busStrobe_t StrobeIdle = '{Ale: 1'b0, nMe: 1'b1, nOe: 1'b1, nWe: 1'b1};
	localparam datapathCtrl_t DpIdle = '{
		AluEn: 1'b0, AluWe: 1'b0, AluOr: NoOr, ImmSel: ImmLong, IrWe: 1'b0,
		MemEn: 1'b0, Enb: 1'b0, Op1Sel: Op1Rd1, Op2Sel: Op2Imm, PcEn: 1'b0,
		PcSel: Pc1, PcWe: 1'b0, RegWe: 1'b0, Rs1Sel: Rs1Ra, RwSel: RwRd,
		WdSel: WdAlu
	};

	logic IsReti;

	assign IsReti = (Opcode == INTERRUPT) && (Branch == CodeReti);

	always_comb begin
		Strobe = StrobeIdle;
		Dp = DpIdle;
		StatusWe = 1'b0;
		IntEnable = 1'b0;
		IntDisable = 1'b0;
		case (SubPhase)
			// Address phase for every bus access
			cycle0: begin
				Strobe.Ale = 1'b1;
				if (Phase == fetch) begin
					Dp.PcEn = 1'b1;
				end else begin
					Dp.AluEn = 1'b1;
					Dp.ImmSel = ImmShort;
					if (IsReti || (Phase == interrupt)) begin
						Dp.Op2Sel = Op2Zero;
						Dp.Rs1Sel = Rs1Sp;
					end
					if (Phase == interrupt)
						Dp.AluOr = SubOr;
				end
			end
			cycle1: begin
				Strobe.nMe = 1'b0;
				if (Phase == fetch) begin
					Dp.PcEn = 1'b1;
				end else begin
					Dp.AluEn = 1'b1;
					Dp.Op2Sel = Op2Zero;
					if (IsReti) begin
						Dp.Rs1Sel = Rs1Sp;
					end else if (Phase == execute) begin
						// Store data or load address passes through the ALU
						Dp.Rs1Sel = Rs1Rd;
						Dp.AluWe = 1'b1;
					end
				end
			end
			cycle2: begin
				Strobe.nMe = 1'b0;
				case (Phase)
					fetch: begin
						Strobe.nOe = 1'b0;
						Dp.MemEn = 1'b1;
						Dp.Enb = 1'b1;
						Dp.IrWe = nWait;
					end
					execute: begin
						Dp.PcWe = nWait;
						if (Opcode == STW) begin
							Dp.AluEn = 1'b1;
							Dp.Op2Sel = Op2Zero;
						end else begin
							Strobe.nOe = 1'b0;
							Dp.MemEn = 1'b1;
							Dp.Enb = 1'b1;
							if (IsReti) begin
								Dp.PcSel = PcSysbus;
							end else begin
								Dp.WdSel = WdSys;
								Dp.RegWe = 1'b1;
							end
						end
					end
					default:
						Dp.PcEn = 1'b1;
				endcase
			end
			cycle3: begin
				Dp.PcEn = (Phase != execute) || (Opcode != STW);
				if (Phase == interrupt) begin
					// Return address goes out while the vector loads
					Strobe.nWe = 1'b0;
					Dp.PcWe = 1'b1;
					Dp.PcSel = PcInt;
				end else if ((Phase == execute) && (Opcode == STW)) begin
					Strobe.nWe = 1'b0;
					Dp.AluEn = 1'b1;
					Dp.Op2Sel = Op2Zero;
				end else if ((Phase == execute) && IsReti) begin
					// Pop the stack pointer back
					Dp.Rs1Sel = Rs1Sp;
					Dp.Op2Sel = Op2Zero;
					Dp.AluOr = AddOr;
					Dp.RwSel = RwSp;
					Dp.RegWe = 1'b1;
				end
			end
			cycle4: begin
				if (Phase == interrupt) begin
					IntDisable = 1'b1;
					Dp.AluEn = 1'b1;
					Dp.AluWe = 1'b1;
					Dp.AluOr = SubOr;
					Dp.Op2Sel = Op2Zero;
					Dp.Rs1Sel = Rs1Sp;
					Dp.RwSel = RwSp;
					Dp.RegWe = 1'b1;
				end else begin
					case (Opcode)
						ADD, ADDI, ADDIB, ADC, ADCI, SUB, SUBI, SUBIB, SUC, SUCI, NEG,
						AND, OR, XOR, NOT, NAND, NOR, LSL, LSR, ASR, CMP, CMPI: begin
							Dp.PcEn = 1'b1;
							Dp.PcWe = 1'b1;
							StatusWe = 1'b1;
							// Compares only update the flags
							Dp.RegWe = (Opcode != CMP) && (Opcode != CMPI);
							case (Opcode)
								ADD, SUB, CMP, AND, OR, XOR, NAND, NOR:
									Dp.Op2Sel = Op2Rd2;
								ADDI, SUBI, CMPI, LSL, LSR, ASR:
									Dp.ImmSel = ImmShort;
								ADDIB, SUBIB:
									Dp.Rs1Sel = Rs1Rd;
								default: ;
							endcase
						end
						LUI, LLI: begin
							Dp.AluEn = 1'b1;
							Dp.Rs1Sel = Rs1Rd;
							Dp.RegWe = 1'b1;
							Dp.PcWe = 1'b1;
						end
						BRANCH: begin
							Dp.AluEn = 1'b1;
							Dp.PcWe = 1'b1;
							Dp.PcSel = Taken ? PcAluOut : Pc1;
							// JMP is register relative, the rest PC relative
							if (Branch == JMP)
								Dp.ImmSel = ImmShort;
							else
								Dp.Op1Sel = Op1Pc;
						end
						// Effective address ahead of the bus cycle
						LDW, STW: begin
							Dp.AluEn = 1'b1;
							Dp.AluWe = 1'b1;
							Dp.ImmSel = ImmShort;
						end
						INTERRUPT: begin
							if (IsReti) begin
								Dp.AluEn = 1'b1;
								Dp.AluWe = 1'b1;
								Dp.ImmSel = ImmShort;
								Dp.Op2Sel = Op2Zero;
								Dp.Rs1Sel = Rs1Sp;
							end else begin
								Dp.PcEn = 1'b1;
								Dp.PcWe = 1'b1;
								IntEnable = (Branch == CodeEi);
								IntDisable = (Branch == CodeDi);
							end
						end
						default: ;
					endcase
				end
			end
			default: ;
		endcase
	end

	// Settled value only, the inputs change in more than one delta
	always_comb begin
		assert final (Strobe.nOe || Strobe.nWe)
			else $error("output and write enables both active");
	end

endmodule

`default_nettype wire

/* rtl/controlUnit.sv */
// Control unit top level with interrupt sync, status flags, phase sequencer and decoder
`timescale 1ns/1ps
`default_nettype none

module controlUnit
	import isaPkg::*, ctrlPkg::*;
#(
	parameter int SyncStages = 2
) (
	input wire logic Clock,
	input wire logic nReset,
	input wire instrCode_t Instr,
	input wire flags_t AluFlags,
	input wire logic nIrq,
	input wire logic nWait,
	output busStrobe_t Strobe,
	output datapathCtrl_t Dp,
	output flags_t StatusReg,
	output logic CFlag
);

	opcode_t Opcode;
	branchCode_t Branch;
	phase_t Phase;
	subPhase_t SubPhase;
	logic IntReq;
	logic IntEnable;
	logic IntDisable;
	logic StatusWe;
	logic Taken;

	assign Opcode = opcode_t'(Instr[7:3]);
	assign Branch = branchCode_t'(Instr[2:0]);
	assign CFlag = StatusReg[FlagC];

	irqSync #(
		.SyncStages(SyncStages)
	) u_irqSync (
		.Clock(Clock),
		.nReset(nReset),
		.nIrq(nIrq),
		.IntEnable(IntEnable),
		.IntDisable(IntDisable),
		.IntReq(IntReq)
	);

	statusFlags u_statusFlags (
		.Clock(Clock),
		.nReset(nReset),
		.AluFlags(AluFlags),
		.StatusWe(StatusWe),
		.Branch(Branch),
		.StatusReg(StatusReg),
		.Taken(Taken)
	);

	phaseSequencer u_phaseSequencer (
		.Clock(Clock),
		.nReset(nReset),
		.Opcode(Opcode),
		.Branch(Branch),
		.IntReq(IntReq),
		.nWait(nWait),
		.Phase(Phase),
		.SubPhase(SubPhase)
	);

	controlDecoder u_controlDecoder (
		.Phase(Phase),
		.SubPhase(SubPhase),
		.Opcode(Opcode),
		.Branch(Branch),
		.Taken(Taken),
		.nWait(nWait),
		.Strobe(Strobe),
		.Dp(Dp),
		.StatusWe(StatusWe),
		.IntEnable(IntEnable),
		.IntDisable(IntDisable)
	);

endmodule

`default_nettype wire

/* rtl/ctrlPkg.sv */
// Control package with phase enums, datapath select enums and the strobe and control structs
`default_nettype none

package ctrlPkg;

	typedef enum logic [1:0] {
		fetch,
		execute,
		interrupt
	} phase_t;

	// Execute starts at cycle4, bus accesses run cycle0 to cycle3
	typedef enum logic [2:0] {
		cycle0,
		cycle1,
		cycle2,
		cycle3,
		cycle4
	} subPhase_t;

	typedef enum logic [1:0] {Pc1, PcAluOut, PcSysbus, PcInt} pcSel_t;
	typedef enum logic {Op1Rd1, Op1Pc} op1Sel_t;
	typedef enum logic [1:0] {Op2Imm, Op2Rd2, Op2Zero} op2Sel_t;
	typedef enum logic {ImmLong, ImmShort} immSel_t;
	// Rs1Sp picks the stack pointer register
	typedef enum logic [1:0] {Rs1Ra, Rs1Rd, Rs1Sp} rs1Sel_t;
	typedef enum logic {RwRd, RwSp} rwSel_t;
	typedef enum logic {WdAlu, WdSys} wdSel_t;
	// ALU override for stack pointer arithmetic
	typedef enum logic [1:0] {NoOr, AddOr, SubOr} aluOr_t;

	// External bus strobes, all but Ale active low
	typedef struct packed {
		logic Ale;
		logic nMe;
		logic nOe;
		logic nWe;
	} busStrobe_t;

	typedef struct packed {
		logic AluEn;
		logic AluWe;
		aluOr_t AluOr;
		immSel_t ImmSel;
		logic IrWe;
		logic MemEn;
		logic Enb;
		op1Sel_t Op1Sel;
		op2Sel_t Op2Sel;
		logic PcEn;
		pcSel_t PcSel;
		logic PcWe;
		logic RegWe;
		rs1Sel_t Rs1Sel;
		rwSel_t RwSel;
		wdSel_t WdSel;
	} datapathCtrl_t;

endpackage

`default_nettype wire

/* rtl/irqSync.sv */
// Interrupt request synchroniser and interrupt enable flag
`timescale 1ns/1ps
`default_nettype none

module irqSync #(
	parameter int SyncStages = 2
) (
	input wire logic Clock,
	input wire logic nReset,
	input wire logic nIrq,
	input wire logic IntEnable,
	input wire logic IntDisable,
	output logic IntReq
);

	// At least two stages expected
	logic [SyncStages-1:0] IrqPipe;
	logic IntEnabled;

	always_ff @(posedge Clock or negedge nReset) begin
		if (!nReset) begin
			IrqPipe <= '0;
			IntEnabled <= 1'b0;
		end else begin
			IrqPipe <= {IrqPipe[SyncStages-2:0], ~nIrq};
			if (IntEnable)
				IntEnabled <= 1'b1;
			else if (IntDisable)
				IntEnabled <= 1'b0;
		end
	end

	assign IntReq = IrqPipe[SyncStages-1] & IntEnabled;

	// EI and DI decode from different instructions
	assert property (@(posedge Clock) disable iff (!nReset) !(IntEnable && IntDisable))
		else $error("interrupt enable and disable requested together");

endmodule

`default_nettype wire

/* rtl/isaPkg.sv */
// Instruction set package with the instruction byte, opcodes, branch codes and flag bits
`default_nettype none

package isaPkg;

	// Opcode in [7:3], branch or interrupt code in [2:0]
	typedef logic [7:0] instrCode_t;

	typedef enum logic [4:0] {
		ADD = 5'd0, ADDI = 5'd1, ADDIB = 5'd2, ADC = 5'd3,
		ADCI = 5'd4, SUB = 5'd5, SUBI = 5'd6, SUBIB = 5'd7,
		SUC = 5'd8, SUCI = 5'd9, NEG = 5'd10, CMP = 5'd11,
		CMPI = 5'd12, AND = 5'd13, OR = 5'd14, XOR = 5'd15,
		NOT = 5'd16, NAND = 5'd17, NOR = 5'd18, LSL = 5'd19,
		LSR = 5'd20, ASR = 5'd21, LUI = 5'd22, LLI = 5'd23,
		BRANCH = 5'd24, LDW = 5'd25, STW = 5'd26, INTERRUPT = 5'd27
	} opcode_t;

	// Branch conditions under BRANCH
	typedef enum logic [2:0] {
		BR = 3'd0,
		BNE = 3'd1,
		BE = 3'd2,
		BLT = 3'd3,
		BGE = 3'd4,
		JMP = 3'd5
	} branchCode_t;

	// Same field reused under INTERRUPT
	localparam branchCode_t CodeReti = branchCode_t'(3'd0);
	localparam branchCode_t CodeEi = branchCode_t'(3'd1);
	localparam branchCode_t CodeDi = branchCode_t'(3'd2);

	typedef logic [3:0] flags_t;

	localparam int FlagZ = 0;
	localparam int FlagC = 1;
	localparam int FlagV = 2;
	localparam int FlagN = 3;

endpackage

`default_nettype wire

/* rtl/phaseSequencer.sv */
// Phase and subphase state machine for fetch, execute and interrupt entry
`timescale 1ns/1ps
`default_nettype none

module phaseSequencer
	import isaPkg::*, ctrlPkg::*;
(
	input wire logic Clock,
	input wire logic nReset,
	input wire opcode_t Opcode,
	input wire branchCode_t Branch,
	input wire logic IntReq,
	input wire logic nWait,
	output phase_t Phase,
	output subPhase_t SubPhase
);

	logic MultiCycle;
	logic IntCtrl;

	// Instructions with a data bus access after cycle4
	assign MultiCycle = (Opcode == LDW) || (Opcode == STW) ||
		((Opcode == INTERRUPT) && (Branch == CodeReti));

	// EI and DI never hand over to interrupt entry directly
	assign IntCtrl = (Opcode == INTERRUPT) && ((Branch == CodeEi) || (Branch == CodeDi));

	always_ff @(posedge Clock or negedge nReset) begin
		if (!nReset) begin
			Phase <= fetch;
			SubPhase <= cycle0;
		end else begin
			case (SubPhase)
				cycle0:
					SubPhase <= cycle1;
				cycle1:
					SubPhase <= cycle2;
				// Stretched by the memory
				cycle2:
					if (nWait)
						SubPhase <= cycle3;
				cycle3: begin
					if (Phase == fetch) begin
						Phase <= execute;
						SubPhase <= cycle4;
					end else if ((Phase == execute) && IntReq) begin
						Phase <= interrupt;
						SubPhase <= cycle4;
					end else begin
						Phase <= fetch;
						SubPhase <= cycle0;
					end
				end
				cycle4: begin
					if ((Phase != execute) || MultiCycle) begin
						SubPhase <= cycle0;
					end else if (IntReq && !IntCtrl) begin
						Phase <= interrupt;
					end else begin
						Phase <= fetch;
						SubPhase <= cycle0;
					end
				end
				default: begin
					Phase <= fetch;
					SubPhase <= cycle0;
				end
			endcase
		end
	end

	assert property (@(posedge Clock) disable iff (!nReset) (Phase == fetch) |-> (SubPhase != cycle4))
		else $error("fetch phase entered cycle4");

endmodule

`default_nettype wire

/* rtl/statusFlags.sv */
// Status register and branch condition evaluation
`timescale 1ns/1ps
`default_nettype none

module statusFlags
	import isaPkg::*;
(
	input wire logic Clock,
	input wire logic nReset,
	input wire flags_t AluFlags,
	input wire logic StatusWe,
	input wire branchCode_t Branch,
	output flags_t StatusReg,
	output logic Taken
);

	always_ff @(posedge Clock or negedge nReset) begin
		if (!nReset)
			StatusReg <= '0;
		else if (StatusWe)
			StatusReg <= AluFlags;
	end

	// Conditions always use the stored flags, never the live ALU ones
	always_comb begin
		case (Branch)
			BR, JMP:
				Taken = 1'b1;
			BNE:
				Taken = !StatusReg[FlagZ];
			BE:
				Taken = StatusReg[FlagZ];
			BLT:
				Taken = StatusReg[FlagN] ^ StatusReg[FlagV];
			BGE:
				Taken = StatusReg[FlagN] ~^ StatusReg[FlagV];
			default:
				Taken = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build the control unit testbench with Verilator and run it

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
	echo "cannot enter the project directory"
	exit 1
fi

verilator --binary --timing --assert -f src.f --top-module tbControlUnit -o simControlUnit
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

output=$(./obj_dir/simControlUnit)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "No errors"; then
	exit 0
fi
exit 1

/* src.f */
rtl/isaPkg.sv
rtl/ctrlPkg.sv
rtl/irqSync.sv
rtl/statusFlags.sv
rtl/phaseSequencer.sv
rtl/controlDecoder.sv
rtl/controlUnit.sv
testbench/tbControlUnit.sv

/* testbench/tbControlUnit.sv */
// Testbench for the control unit with data file stimulus, per-test checks and a watchdog
`timescale 1ns/1ps
`default_nettype none

module tbControlUnit
	import isaPkg::*, ctrlPkg::*;
;

	// One line of the data file
	typedef struct packed {
		logic [7:0] Instr;
		logic [3:0] Flags;
		logic Irq;
		logic [3:0] Wait;
		logic [7:0] Cycles;
		logic [1:0] PcSel;
		logic RegWe;
		logic [3:0] Status;
	} testVec_t;

	logic Clock;
	logic nReset;
	instrCode_t Instr;
	flags_t AluFlags;
	logic nIrq;
	logic nWait;
	busStrobe_t Strobe;
	datapathCtrl_t Dp;
	flags_t StatusReg;
	logic CFlag;

	testVec_t vecs[$];
	string names[$];
	string testName;
	int errors = 0;
	int failedTests = 0;
	int waitLeft = 0;
	int testWait = 0;
	logic prevNMe = 1'b1;
	logic loaded = 1'b0;
	logic [31:0] rng = 32'hbe8c;

	controlUnit #(
		.SyncStages(2)
	) u_controlUnit (
		.Clock(Clock),
		.nReset(nReset),
		.Instr(Instr),
		.AluFlags(AluFlags),
		.nIrq(nIrq),
		.nWait(nWait),
		.Strobe(Strobe),
		.Dp(Dp),
		.StatusReg(StatusReg),
		.CFlag(CFlag)
	);

	initial begin
		Clock = 1'b0;
		forever #5 Clock = ~Clock;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic check(input string what, input int expected, input int actual);
		if (expected !== actual) begin
			$display("error %s %s: expected %0d, actual %0d", testName, what, expected, actual);
			errors++;
		end
	endtask

	// Called on a falling edge; stalls cycle2 for testWait cycles, noise elsewhere
	task automatic driveWait();
		logic inCycle2;
		inCycle2 = !Strobe.nMe && !prevNMe;
		if (Strobe.Ale)
			waitLeft = testWait;
		if (inCycle2 && waitLeft > 0) begin
			nWait = 1'b0;
			waitLeft--;
		end else if (inCycle2) begin
			nWait = 1'b1;
		end else begin
			rng = xorshift(rng);
			nWait = rng[0];
		end
		prevNMe = Strobe.nMe;
	endtask

	// Entered on the falling edge of a fetch cycle0, leaves on the next one
	task automatic runTest(input int t);
		testVec_t vec;
		opcode_t op;
		logic multi, isLdw, isStw, isReti, entry, sawPcInt, sawSysbus, done;
		logic [1:0] execPcSel;
		logic execRegWe;
		int cycles, irWeCount, nWeCount, nWeIdx, regWeIdx, execIdx, baseCycles, errorsBefore;
		vec = vecs[t];
		testName = names[t];
		op = opcode_t'(vec.Instr[7:3]);
		isLdw = (op == LDW);
		isStw = (op == STW);
		isReti = (op == INTERRUPT) && (vec.Instr[2:0] == 3'd0);
		multi = isLdw || isStw || isReti;
		execIdx = 4 + int'(vec.Wait);
		baseCycles = multi ? 9 + 2 * int'(vec.Wait) : 5 + int'(vec.Wait);
		// An interrupt entry adds 5+W cycles
		entry = (int'(vec.Cycles) == baseCycles + 5 + int'(vec.Wait));
		Instr = vec.Instr;
		AluFlags = vec.Flags;
		nIrq = !vec.Irq;
		testWait = int'(vec.Wait);
		errorsBefore = errors;
		cycles = 0;
		irWeCount = 0;
		nWeCount = 0;
		nWeIdx = -1;
		regWeIdx = -1;
		execPcSel = 2'd0;
		execRegWe = 1'b0;
		sawPcInt = 1'b0;
		sawSysbus = 1'b0;
		done = 1'b0;
		while (!done) begin
			driveWait();
			#1;
			check("nOe and nWe both low", 0, int'(!Strobe.nOe && !Strobe.nWe));
			if (Dp.IrWe)
				irWeCount++;
			if (!Strobe.nWe) begin
				nWeCount++;
				nWeIdx = cycles;
			end
			if (cycles == execIdx) begin
				execPcSel = Dp.PcSel;
				execRegWe = Dp.RegWe;
			end
			if (cycles > execIdx && Dp.RegWe && regWeIdx < 0)
				regWeIdx = cycles;
			if (Dp.PcWe && Dp.PcSel == PcInt)
				sawPcInt = 1'b1;
			if (Dp.PcSel == PcSysbus)
				sawSysbus = 1'b1;
			cycles++;
			@(negedge Clock);
			done = Strobe.Ale && Dp.PcEn;
		end
		check("cycles", int'(vec.Cycles), cycles);
		check("IrWe pulses", 1, irWeCount);
		check("execute PcSel", int'(vec.PcSel), int'(execPcSel));
		check("execute RegWe", int'(vec.RegWe), int'(execRegWe));
		check("StatusReg", int'(vec.Status), int'(StatusReg));
		check("CFlag", int'(vec.Status[FlagC]), int'(CFlag));
		check("interrupt entry", int'(entry), int'(sawPcInt));
		check("PcSysbus", int'(isReti), int'(sawSysbus));
		check("nWe cycles", int'(isStw || entry), nWeCount);
		if (nWeCount == 1)
			check("nWe cycle", cycles - 1, nWeIdx);
		// LDW writes the register in execute cycle2
		if (isLdw)
			check("LDW RegWe cycle", execIdx + 3, regWeIdx);
		if (errors != errorsBefore)
			failedTests++;
		$display("%s: %0d cycles, %s", testName, cycles, (errors == errorsBefore) ? "ok" : "failed");
	endtask

	initial begin
		string line;
		string name;
		int fd, n, instr, flags, irq, w, cyc, pcSel, regWe, status;
		testVec_t vec;
		nReset = 1'b0;
		Instr = '0;
		AluFlags = '0;
		nIrq = 1'b1;
		nWait = 1'b1;
		fd = $fopen("testbench/testdata.txt", "r");
		if (fd == 0) begin
			$display("cannot open testbench/testdata.txt");
			errors++;
		end else begin
			while ($fgets(line, fd) != 0) begin
				if (line.len() > 1 && line[0] != "#") begin
					n = $sscanf(line, "%s %h %h %d %d %d %d %d %h",
						name, instr, flags, irq, w, cyc, pcSel, regWe, status);
					if (n == 9) begin
						vec = '{instr[7:0], flags[3:0], irq[0], w[3:0], cyc[7:0],
							pcSel[1:0], regWe[0], status[3:0]};
						vecs.push_back(vec);
						names.push_back(name);
					end
				end
			end
			$fclose(fd);
		end
		if (vecs.size() == 0) begin
			$display("no tests were read from the data file");
			errors++;
		end
		loaded = 1'b1;
		repeat (5) @(posedge Clock);
		@(negedge Clock);
		nReset = 1'b1;
		foreach (vecs[t])
			runTest(t);
		$display("tests run: %0d, tests failed: %0d, mismatches: %0d",
			vecs.size(), failedTests, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

	// Each test is well under 40 cycles
	initial begin
		wait (loaded);
		#((vecs.size() * 40 + 10) * 10);
		$display("simulation timed out before all tests finished");
		$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

/* testbench/testdata.txt */
# name instr(hex) aluflags(hex, N V C Z) irq waits cycles pcsel regwe status(hex)
# cycles run from one fetch to the next, pcsel and regwe are sampled in execute cycle4
add_c 00 2 0 0 5 0 1 2
sub_nc 28 a 0 2 7 0 1 a
cmp_z 58 1 0 1 6 0 0 1
bne_not c1 0 0 0 5 0 0 1
be_taken c2 f 0 1 6 1 0 1
cmpi_n 60 8 0 0 5 0 0 8
blt_taken c3 0 0 0 5 1 0 8
bge_not c4 0 0 3 8 0 0 8
cmp_nv 58 c 0 0 5 0 0 c
bge_taken c4 0 0 0 5 1 0 c
blt_not c3 0 0 1 6 0 0 c
br c0 0 0 0 5 1 0 c
jmp c5 0 0 2 7 1 0 c
lui b0 3 0 0 5 0 1 c
lli b8 0 0 1 6 0 1 c
ldw_w0 c8 0 0 0 9 0 0 c
ldw_w2 c8 0 0 2 13 0 0 c
stw_w1 d0 0 0 1 11 0 0 c
ei d9 0 0 0 5 0 0 c
xor_irq 78 4 1 1 12 0 1 4
add_masked 00 0 1 0 5 0 1 0
ei_again d9 0 0 0 5 0 0 0
di da 0 0 1 6 0 0 0
add_after_di 00 2 1 0 5 0 1 2
reti d8 0 0 1 11 0 0 2
stw_w0 d0 0 0 0 9 0 0 2
